// ==== verilog/lcdPkg.sv ====
package lcdPkg;

	//----------------------------------------------------------------------
	// timing, all counts in clock cycles at 50 MHz
	//----------------------------------------------------------------------
	typedef logic [31:0] delay_t; // every timer count travels as this

	localparam delay_t powerUpCycles = 32'd750000; // 15 ms after reset
	localparam delay_t pulseCycles = 32'd12; // enable high time
	localparam delay_t nibbleGapCycles = 32'd50; // ~1 us between byte halves

	// settle after a wake nibble or a full byte
	localparam delay_t settle4msCycles = 32'd205000; // 4.1 ms
	localparam delay_t settle100usCycles = 32'd5000;
	localparam delay_t settle40usCycles = 32'd2000;
	localparam delay_t settleClearCycles = 32'd82000; // 1.64 ms, clear is slow

	localparam logic [7:0] displayChar = 8'h42; // 'B'

	//----------------------------------------------------------------------
	// command bytes
	//----------------------------------------------------------------------
	typedef enum logic [7:0]
	{
		opFunctionSet = 8'h28, // 4-bit bus, 2 lines, 5x8 font
		opEntryMode = 8'h06, // increment, no shift
		opDisplayOn = 8'h0C, // display on, cursor and blink off
		opClear = 8'h01,
		opSetAddress = 8'h80 // DD RAM address 0
	} lcdOpcode_e;

	typedef enum logic [1:0]
	{
		kindWake, // one nibble only, low half of value
		kindCommand, // full byte, RS low
		kindData // full byte, RS high
	} requestKind_e;

	typedef enum logic [1:0]
	{
		settle4ms,
		settle100us,
		settle40us,
		settleClear
	} settle_e;

	// one write job from sequencer to writer
	typedef struct packed
	{
		requestKind_e kind;
		logic [7:0] value;
		settle_e settle;
	} lcdRequest_t;

	// pins toward the panel
	typedef struct packed
	{
		logic enable;
		logic registerSelect; // 0 command, 1 data
		logic [3:0] data; // DB7..DB4
	} lcdBus_t;

	typedef enum logic [3:0]
	{
		stPowerUp,
		stWake0, stWake1, stWake2, stWake3,
		stFunctionSet, stEntryMode, stDisplayOn, stClear, stSetAddress,
		stReady,
		stWriteChar,
		stDone
	} seqState_e;

endpackage

// ==== verilog/delayTimer.sv ====
`timescale 1ns/1ps

module delayTimer
	import lcdPkg::*;
(
	input logic Clock,
	input logic rstN,
	input logic start,
	input delay_t count,
	output logic done
);

	delay_t remaining; // cycles left including the done cycle
	logic armed; // one done per start

	// fires count cycles after the start cycle
	assign done = armed && (remaining == delay_t'(1));

	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			armed <= 1'b0;
			remaining <= '0;
		end
		else if (start) // restart wins over a pending done
		begin
			armed <= 1'b1;
			remaining <= count;
		end
		else if (armed)
		begin
			remaining <= remaining - delay_t'(1);
			if (done)
				armed <= 1'b0; // idle until next start
		end
	end

endmodule

// ==== verilog/lcdWriter.sv ====
`timescale 1ns/1ps

module lcdWriter
	import lcdPkg::*;
(
	input logic Clock,
	input logic rstN,
	input logic requestValid,
	input lcdRequest_t request,
	output logic writeDone,
	output lcdBus_t lcd
);

	typedef enum logic [2:0]
	{
		phIdle,
		phUpper, // first enable pulse, also the only one for wake
		phGap,
		phLower,
		phSettle
	} phase_e;

	phase_e phase;
	lcdRequest_t held; // request captured on the strobe
	logic timerStart;
	delay_t timerCount;
	logic timerDone;
	delay_t settleCount;

	// settle selector to cycles
	function automatic delay_t settleCycles(input settle_e sel);
		delay_t cycles;
		case (sel)
			settle4ms: cycles = settle4msCycles;
			settle100us: cycles = settle100usCycles;
			settle40us: cycles = settle40usCycles;
			settleClear: cycles = settleClearCycles;
			default: cycles = settle40usCycles;
		endcase
		return cycles;
	endfunction

	assign settleCount = settleCycles(held.settle);

	//----------------------------------------------------------------------
	// phase timer control
	//----------------------------------------------------------------------
	always_comb
	begin
		timerStart = 1'b0;
		timerCount = pulseCycles; // default is enable width
		case (phase)
			phIdle: timerStart = requestValid;
			phUpper:
			begin
				timerStart = timerDone;
				// wake goes straight to settle, byte waits for its second half
				timerCount = (held.kind == kindWake) ? settleCount : nibbleGapCycles;
			end
			phGap: timerStart = timerDone; // lower pulse width
			phLower:
			begin
				timerStart = timerDone;
				timerCount = settleCount;
			end
			default: timerStart = 1'b0; // settle runs out on its own
		endcase
	end

	delayTimer phaseTimer
	(
		.Clock(Clock),
		.rstN(rstN),
		.start(timerStart),
		.count(timerCount),
		.done(timerDone)
	);

	always_ff @(posedge Clock)
	begin
		if (phase == phIdle && requestValid)
			held <= request;
	end

	//----------------------------------------------------------------------
	// phase machine and registered bus
	//----------------------------------------------------------------------
	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			phase <= phIdle;
			writeDone <= 1'b0;
			lcd <= '0;
		end
		else
		begin
			writeDone <= 1'b0;
			case (phase)
				phIdle:
					if (requestValid)
					begin
						phase <= phUpper;
						lcd.enable <= 1'b1; // rises the cycle after the strobe
						lcd.registerSelect <= (request.kind == kindData);
						lcd.data <= (request.kind == kindWake) ? request.value[3:0]
							: request.value[7:4];
					end
				phUpper:
					if (timerDone)
					begin
						lcd.enable <= 1'b0;
						phase <= (held.kind == kindWake) ? phSettle : phGap;
					end
				phGap:
				begin
					// swaps one cycle after the fall, long before the next rise
					lcd.data <= held.value[3:0];
					if (timerDone)
					begin
						lcd.enable <= 1'b1;
						phase <= phLower;
					end
				end
				phLower:
					if (timerDone)
					begin
						lcd.enable <= 1'b0;
						phase <= phSettle;
					end
				phSettle:
					if (timerDone)
					begin
						phase <= phIdle;
						writeDone <= 1'b1; // writer already idle here
					end
				default: phase <= phIdle;
			endcase
		end
	end

endmodule

// ==== verilog/initSequencer.sv ====
`timescale 1ns/1ps

module initSequencer
	import lcdPkg::*;
(
	input logic Clock,
	input logic rstN,
	input logic writeDone,
	input logic timerDone,
	output logic timerStart,
	output delay_t timerCount,
	output logic requestValid,
	output lcdRequest_t request,
	output logic ready
);

	seqState_e state;
	logic waitStarted; // power-up timer already kicked

	//----------------------------------------------------------------------
	// step table
	//----------------------------------------------------------------------
	function automatic lcdRequest_t stepRequest(input seqState_e step);
		lcdRequest_t req;
		case (step)
			stWake0: req = '{kindWake, 8'h03, settle4ms};
			stWake1: req = '{kindWake, 8'h03, settle100us};
			stWake2: req = '{kindWake, 8'h03, settle40us};
			stWake3: req = '{kindWake, 8'h02, settle40us}; // switch to 4-bit
			stFunctionSet: req = '{kindCommand, opFunctionSet, settle40us};
			stEntryMode: req = '{kindCommand, opEntryMode, settle40us};
			stDisplayOn: req = '{kindCommand, opDisplayOn, settle40us};
			stClear: req = '{kindCommand, opClear, settleClear};
			stSetAddress: req = '{kindCommand, opSetAddress, settle40us};
			stWriteChar: req = '{kindData, displayChar, settle40us};
			default: req = '{kindCommand, 8'h00, settle40us}; // never strobed
		endcase
		return req;
	endfunction

	// plain successor, wake0 up to clear
	function automatic seqState_e nextStep(input seqState_e step);
		seqState_e next;
		case (step)
			stWake0: next = stWake1;
			stWake1: next = stWake2;
			stWake2: next = stWake3;
			stWake3: next = stFunctionSet;
			stFunctionSet: next = stEntryMode;
			stEntryMode: next = stDisplayOn;
			stDisplayOn: next = stClear;
			stClear: next = stSetAddress;
			default: next = stDone;
		endcase
		return next;
	endfunction

	// request follows the state, stable for the whole step
	assign request = stepRequest(state);

	// power-up wait starts in the first cycle out of reset
	assign timerStart = (state == stPowerUp) && !waitStarted;
	assign timerCount = powerUpCycles;

	//----------------------------------------------------------------------
	// step machine
	//----------------------------------------------------------------------
	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			state <= stPowerUp;
			waitStarted <= 1'b0;
			requestValid <= 1'b0;
			ready <= 1'b0;
		end
		else
		begin
			requestValid <= 1'b0; // strobes are single cycle
			ready <= 1'b0;
			if (state == stPowerUp)
				waitStarted <= 1'b1;
			case (state)
				stPowerUp:
					if (timerDone)
					begin
						state <= stWake0;
						requestValid <= 1'b1;
					end
				stSetAddress:
					if (writeDone)
					begin
						state <= stReady;
						ready <= 1'b1; // panel set up, one-cycle pulse
					end
				stReady:
				begin
					state <= stWriteChar;
					requestValid <= 1'b1;
				end
				stWriteChar:
					if (writeDone)
						state <= stDone;
				stDone: state <= stDone; // parked until reset
				default:
					if (writeDone) // wake nibbles and config bytes
					begin
						state <= nextStep(state);
						requestValid <= 1'b1;
					end
			endcase
		end
	end

endmodule

// ==== verilog/lcdControl.sv ====
`timescale 1ns/1ps

module lcdControl
	import lcdPkg::*;
(
	input logic Clock,
	input logic rstN,
	output lcdBus_t lcd,
	output logic ready
);

	logic timerStart;
	delay_t timerCount;
	logic timerDone;
	logic requestValid;
	lcdRequest_t request;
	logic writeDone;

	initSequencer sequencer
	(
		.Clock(Clock),
		.rstN(rstN),
		.writeDone(writeDone),
		.timerDone(timerDone),
		.timerStart(timerStart),
		.timerCount(timerCount),
		.requestValid(requestValid),
		.request(request),
		.ready(ready)
	);

	// 15 ms wait before the first wake nibble
	delayTimer powerUpTimer
	(
		.Clock(Clock),
		.rstN(rstN),
		.start(timerStart),
		.count(timerCount),
		.done(timerDone)
	);

	lcdWriter writer
	(
		.Clock(Clock),
		.rstN(rstN),
		.requestValid(requestValid),
		.request(request),
		.writeDone(writeDone),
		.lcd(lcd)
	);

endmodule

// ==== bench/lcdControlTb.sv ====
`timescale 1ns/1ps

module lcdControlTb
	import lcdPkg::*;
;

	localparam int numItems = 10; // 4 wake nibbles, 5 commands, 1 character

	typedef struct packed
	{
		requestKind_e kind;
		logic [7:0] value;
		delay_t settle; // minimum low time after the item
	} stepExp_t;

	// one item as seen on the pins
	typedef struct packed
	{
		int index;
		logic [7:0] value;
		logic rs;
		int width0; // first enable pulse
		int gap; // low time between byte halves
		int width1; // second enable pulse
		int lowBefore; // low time before the first rise
		logic stable; // rs and data held across each pulse
	} capture_t;

	logic Clock;
	logic rstN;
	lcdBus_t lcd;
	logic ready;

	int errors = 0;
	integer seed;
	int resetAt;
	capture_t captured[$];

	// monitor state
	capture_t cur;
	lcdBus_t prevLcd, riseLcd;
	logic prevReady;
	logic inReset = 1'b0;
	int edgeCount, itemIdx, half, highCount, lowCount, readyCount;

	lcdControl DUT
	(
		.Clock(Clock),
		.rstN(rstN),
		.lcd(lcd),
		.ready(ready)
	);

	initial
	begin
		Clock = 1'b0;
		forever #2 Clock = ~Clock; // 4 ns period
	end

	//----------------------------------------------------------------------
	// expected sequence
	//----------------------------------------------------------------------
	function automatic stepExp_t expectedStep(input int index);
		stepExp_t s;
		case (index)
			0: s = '{kindWake, 8'h03, settle4msCycles};
			1: s = '{kindWake, 8'h03, settle100usCycles};
			2: s = '{kindWake, 8'h03, settle40usCycles};
			3: s = '{kindWake, 8'h02, settle40usCycles};
			4: s = '{kindCommand, 8'h28, settle40usCycles}; // function set
			5: s = '{kindCommand, 8'h06, settle40usCycles}; // entry mode
			6: s = '{kindCommand, 8'h0C, settle40usCycles}; // display on
			7: s = '{kindCommand, 8'h01, settleClearCycles};
			8: s = '{kindCommand, 8'h80, settle40usCycles}; // DD address 0
			default: s = '{kindData, displayChar, settle40usCycles};
		endcase
		return s;
	endfunction

	// one whole power-up and write sequence, pins only
	function automatic longint sequenceCycles();
		longint total;
		int i;
		stepExp_t step;
		total = powerUpCycles;
		for (i = 0; i < numItems; i++)
		begin
			step = expectedStep(i);
			total += step.settle + pulseCycles;
			if (i >= 4)
				total += pulseCycles + nibbleGapCycles;
		end
		return total;
	endfunction

	task automatic logMismatch(input string name, input int expected, input int actual);
		$display("Mismatch %s: expected %0d (0x%0h), actual %0d (0x%0h)",
			name, expected, expected, actual, actual);
		errors++;
	endtask

	task automatic compareItem(input capture_t got);
		stepExp_t exp;
		stepExp_t prev;
		int overhead;
		string name;
		exp = expectedStep(got.index);
		name = $sformatf("item %0d", got.index);
		if (got.value != exp.value)
			logMismatch({name, " value"}, exp.value, got.value);
		if (got.rs != (exp.kind == kindData))
			logMismatch({name, " registerSelect"}, exp.kind == kindData, got.rs);
		if (got.width0 != pulseCycles)
			logMismatch({name, " enable width"}, pulseCycles, got.width0);
		if (exp.kind != kindWake)
		begin
			if (got.gap != nibbleGapCycles)
				logMismatch({name, " nibble gap"}, nibbleGapCycles, got.gap);
			if (got.width1 != pulseCycles)
				logMismatch({name, " second enable width"}, pulseCycles, got.width1);
		end
		if (!got.stable)
		begin
			$display("%s: data or registerSelect changed around an enable pulse", name);
			errors++;
		end
		if (got.index > 0)
		begin
			prev = expectedStep(got.index - 1);
			// writeDone cycle and strobe cycle, one more for the ready pulse
			overhead = (exp.kind == kindData) ? 3 : 2;
			if (got.lowBefore != prev.settle + overhead)
				logMismatch({name, " low time before"}, prev.settle + overhead, got.lowBefore);
			if (got.lowBefore < prev.settle)
			begin
				$display("%s: settle before it is shorter than required", name);
				errors++;
			end
		end
	endtask

	//----------------------------------------------------------------------
	// bus monitor, samples pre-edge values
	//----------------------------------------------------------------------
	always @(posedge Clock)
	begin
		if (!rstN)
		begin
			if (inReset && (lcd != '0 || ready))
			begin
				$display("LCD outputs or ready not low during reset");
				errors++;
			end
			inReset = 1'b1;
			edgeCount = 0;
			itemIdx = 0;
			half = 0;
			highCount = 0;
			lowCount = 0;
			readyCount = 0;
			prevLcd = '0;
			prevReady = 1'b0;
		end
		else
		begin
			inReset = 1'b0;
			edgeCount++;
			if (ready)
			begin
				readyCount++;
				if (prevReady)
				begin
					$display("ready held high for more than one cycle");
					errors++;
				end
				if (itemIdx != 9 || half != 0 || lcd.enable)
				begin
					$display("ready pulsed outside the gap between 0x80 and the character");
					errors++;
				end
			end
			if (lcd.enable)
			begin
				if (!prevLcd.enable) // rise
				begin
					if (itemIdx >= numItems)
					begin
						$display("enable pulse after the character write");
						errors++;
					end
					// enable set at edge powerUp+2, seen here one edge later
					if (itemIdx == 0 && edgeCount != powerUpCycles + 3)
						logMismatch("first enable rise", powerUpCycles + 2, edgeCount - 1);
					if (half == 0)
					begin
						cur = '0;
						cur.stable = 1'b1;
						cur.lowBefore = lowCount;
					end
					else
						cur.gap = lowCount;
					highCount = 0;
					riseLcd = lcd;
				end
				highCount++;
				if (lcd.registerSelect != riseLcd.registerSelect || lcd.data != riseLcd.data)
					cur.stable = 1'b0;
			end
			else
			begin
				if (prevLcd.enable) // fall
				begin
					lowCount = 0;
					if (lcd.registerSelect != riseLcd.registerSelect || lcd.data != riseLcd.data)
						cur.stable = 1'b0; // must hold one cycle past the fall
					if (half == 0)
					begin
						cur.width0 = highCount;
						cur.rs = riseLcd.registerSelect;
						cur.value = (itemIdx < 4) ? {4'h0, riseLcd.data} : {riseLcd.data, 4'h0};
						half = (itemIdx < 4) ? 0 : 1;
					end
					else
					begin
						cur.width1 = highCount;
						cur.value[3:0] = riseLcd.data;
						if (riseLcd.registerSelect != cur.rs)
							cur.stable = 1'b0;
						half = 0;
					end
					if (half == 0) // item complete
					begin
						cur.index = itemIdx;
						captured.push_back(cur);
						itemIdx++;
					end
				end
				lowCount++;
				if (itemIdx == 0 && (lcd != '0 || ready)) // power-up wait is quiet
				begin
					$display("LCD outputs or ready active during the power-up wait");
					errors++;
				end
			end
			prevLcd = lcd;
			prevReady = ready;
		end
	end

	// checker, drains what the monitor captured
	initial
	begin
		forever
		begin
			@(negedge Clock);
			while (captured.size() > 0)
				compareItem(captured.pop_front());
		end
	end

	//----------------------------------------------------------------------
	// stimulus
	//----------------------------------------------------------------------
	initial
	begin
		seed = 33;
		rstN = 1'b0;
		resetAt = 1 + ({$random(seed)} % 9); // items done before the mid-run reset
		repeat (4) @(negedge Clock);
		rstN = 1'b1;
		while (itemIdx < resetAt)
			@(negedge Clock);
		$display("Applying reset after item %0d", resetAt);
		rstN = 1'b0;
		repeat (4) @(negedge Clock);
		rstN = 1'b1;
		while (itemIdx < numItems)
			@(negedge Clock);
		repeat (settle40usCycles + 100) @(negedge Clock); // bus must stay idle
		if (readyCount != 1)
			logMismatch("ready pulse count", 1, readyCount);
		$display("Checks done, %0d errors", errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	// cycle limit, two sequences with margin
	initial
	begin
		longint limit;
		longint cycles;
		limit = (sequenceCycles() * 2 * 3) / 2;
		cycles = 0;
		while (cycles < limit)
		begin
			@(posedge Clock);
			cycles++;
		end
		$display("Timeout, run did not finish within %0d cycles", limit);
		$display("Verification failed");
		$finish;
	end

endmodule

// ==== verilog.f ====
verilog/lcdPkg.sv
verilog/delayTimer.sv
verilog/lcdWriter.sv
verilog/initSequencer.sv
verilog/lcdControl.sv
bench/lcdControlTb.sv
